/* rtl/fifo_wr_if.sv */
// Output FIFO write side and status
// wen must stay low while full is high
interface fifo_wr_if import pack_pkg::*; ();

  logic [ENTRY_W-1:0] wdata;
  logic               wen;
  logic               full;
  logic               almost_full;

  modport wr   (output wdata);
  modport ctl  (output wen, input full);
  modport fifo (input wdata, wen, output full, almost_full);

endinterface

/* rtl/lane_counter.sv */
// Lane index for the word being assembled
// clear has priority over advance
module lane_counter import pack_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  pack_ctrl_if.cnt ctrl
);

  logic [LANE_W-1:0] lane_q;

  always_ff @(posedge clk) begin
    if (!rst_n)
      lane_q <= '0;
    else if (ctrl.clear)
      lane_q <= '0;
    else if (ctrl.advance)
      lane_q <= lane_q + 1'b1;   // Wraps after the top lane
  end

  assign ctrl.lane      = lane_q;
  assign ctrl.lane_term = (lane_q == LANE_W'(LANES - 1));

endmodule

/* rtl/out_fifo.sv */
// Five-entry output FIFO whose first word falls through to rd_data
// rd_en while empty is ignored; writer keeps wen low when full
module out_fifo import pack_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  fifo_wr_if.fifo            wr,
  input  logic               rd_en,
  output logic [ENTRY_W-1:0] rd_data,
  output logic               empty
);

  logic [ENTRY_W-1:0] mem [FIFO_DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;
  logic               do_wr;
  logic               do_rd;

  assign do_wr = wr.wen && !wr.full;
  assign do_rd = rd_en && !empty;

  always_ff @(posedge clk) begin
    if (do_wr)
      mem[wr_ptr] <= wr.wdata;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr)
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_rd)
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;   // Both or neither
      endcase
    end
  end

  assign rd_data = mem[rd_ptr];
  assign empty   = (count == '0);
  assign wr.full = (count == CNT_W'(FIFO_DEPTH));

  // Free entries at or below the threshold
  assign wr.almost_full = (CNT_W'(FIFO_DEPTH) - count) <= CNT_W'(AF_FREE);

endmodule

/* rtl/pack_ctrl_if.sv */
// Lane control between FSM, lane counter and word assembler
// advance, clear and emit are single-cycle pulses
interface pack_ctrl_if import pack_pkg::*; ();

  logic              advance;
  logic              clear;
  logic              emit;
  logic [LANE_W-1:0] lane;
  logic              lane_term;   // lane is at the top position

  modport fsm (
    output advance, clear, emit,
    input  lane_term
  );

  modport cnt (
    input  advance, clear,
    output lane, lane_term
  );

  modport asm (
    input advance, clear, emit, lane, lane_term
  );

endinterface

/* rtl/pack_fsm.sv */
// Packing control. Outputs are combinational from state and inputs
// A word that meets a full FIFO is dropped along with the rest of its packet
module pack_fsm import pack_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        in_valid,
  input  logic        in_last,
  output logic        overrun,
  pack_ctrl_if.fsm    ctrl,
  fifo_wr_if.ctl      wr
);

  pack_state_t state, state_nxt;
  logic        accept;
  logic        need_emit;
  logic        lost;

  assign accept    = in_valid && (state != ST_DISCARD);
  assign need_emit = accept && (ctrl.lane_term || in_last);
  assign lost      = need_emit && wr.full;   // No room for this word

  assign ctrl.advance = accept;
  assign ctrl.clear   = need_emit;   // Also flushes lanes on overrun
  assign ctrl.emit    = need_emit && !wr.full;
  assign wr.wen       = ctrl.emit;

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE, ST_ACCUM: begin
        if (accept) begin
          if (lost && !in_last)
            state_nxt = ST_DISCARD;
          else if (in_last)
            state_nxt = ST_IDLE;
          else
            state_nxt = ST_ACCUM;
        end
      end
      ST_DISCARD: begin
        if (in_valid && in_last)
          state_nxt = ST_IDLE;   // Next packet starts clean
      end
      default: state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= ST_IDLE;
      overrun <= 1'b0;
    end else begin
      state <= state_nxt;
      if (lost)
        overrun <= 1'b1;   // Sticky until reset
    end
  end

endmodule

/* rtl/pack_pkg.sv */
// Widths and depths for the sample packer
// One FIFO entry is the last bit on top of four 16-bit lanes
package pack_pkg;

  localparam int SAMPLE_W = 16;
  localparam int LANES    = 4;
  localparam int LANE_W   = 2;
  localparam int DATA_W   = SAMPLE_W * LANES;
  localparam int ENTRY_W  = DATA_W + 1;   // Bit 64 is the last bit

  localparam int FIFO_DEPTH = 5;
  localparam int PTR_W      = 3;
  localparam int CNT_W      = 3;

  // Stall is raised once free entries drop to this
  localparam int AF_FREE = 1;

  typedef enum logic [1:0] {
    ST_IDLE    = 2'd0,
    ST_ACCUM   = 2'd1,
    ST_DISCARD = 2'd2
  } pack_state_t;

endpackage

/* rtl/sample_packer.sv */
// Packs 16-bit strobed samples four to a 64-bit word with a last flag
// Producer should stop strobing while stall is high; overrun is sticky
module sample_packer import pack_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                in_valid,
  input  logic [SAMPLE_W-1:0] in_sample,
  input  logic                in_last,
  output logic                stall,
  output logic                overrun,
  input  logic                rd_en,
  output logic [DATA_W-1:0]   out_data,
  output logic                out_last,
  output logic                out_empty,
  output logic                out_full
);

  pack_ctrl_if ctrl_bus ();
  fifo_wr_if   wr_bus ();

  logic [ENTRY_W-1:0] rd_data;

  pack_fsm u_fsm (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .in_last  (in_last),
    .overrun  (overrun),
    .ctrl     (ctrl_bus.fsm),
    .wr       (wr_bus.ctl)
  );

  lane_counter u_lane_cnt (
    .clk   (clk),
    .rst_n (rst_n),
    .ctrl  (ctrl_bus.cnt)
  );

  word_assembler u_asm (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_sample (in_sample),
    .in_last   (in_last),
    .ctrl      (ctrl_bus.asm),
    .wr        (wr_bus.wr)
  );

  out_fifo u_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr      (wr_bus.fifo),
    .rd_en   (rd_en),
    .rd_data (rd_data),
    .empty   (out_empty)
  );

  assign out_data = rd_data[DATA_W-1:0];
  assign out_last = rd_data[ENTRY_W-1];
  assign out_full = wr_bus.full;
  assign stall    = wr_bus.almost_full;

endmodule

/* rtl/word_assembler.sv */
// Holds lanes 0 to 2; the sample in flight fills the current lane
// Lanes above the current one are zero in the emitted entry
module word_assembler import pack_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [SAMPLE_W-1:0] in_sample,
  input  logic                in_last,
  pack_ctrl_if.asm            ctrl,
  fifo_wr_if.wr               wr
);

  logic [LANES-2:0][SAMPLE_W-1:0] held_q;
  logic [DATA_W-1:0]              data;

  always_ff @(posedge clk) begin
    if (!rst_n || ctrl.clear)
      held_q <= '0;
    else if (ctrl.advance && !ctrl.lane_term)
      held_q[ctrl.lane] <= in_sample;
  end

  always_comb begin
    data = '0;
    for (int i = 0; i < LANES - 1; i++) begin
      if (LANE_W'(i) < ctrl.lane)
        data[i*SAMPLE_W +: SAMPLE_W] = held_q[i];
    end
    data[ctrl.lane*SAMPLE_W +: SAMPLE_W] = in_sample;
  end

  // Entry only driven during emit
  assign wr.wdata = ctrl.emit ? {in_last, data} : '0;

endmodule

/* run.sh */
#!/bin/sh
# Build and run the sample packer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_sample_packer -f vlog.f

out=$(./obj_dir/Vtb_sample_packer)
echo "$out"

# Fails the script unless the pass line is present
echo "$out" | grep -qx "TEST OK"

/* testbench/tb_sample_packer.sv */
// Random stimulus from a 32-bit Fibonacci LFSR is checked against a packer model
// Runs normal traffic, an overrun phase that ignores stall, recovery and a final drain
module tb_sample_packer import pack_pkg::*; ();

  localparam int N_NORMAL   = 600;
  localparam int N_OVERRUN  = 60;
  localparam int N_RECOVER  = 300;
  localparam int N_DRAIN    = FIFO_DEPTH + 2;
  localparam int MAX_CYCLES = 4 * (10 + N_NORMAL + N_OVERRUN + N_RECOVER + N_DRAIN);

  logic                clk;
  logic                rst_n;
  logic                in_valid;
  logic [SAMPLE_W-1:0] in_sample;
  logic                in_last;
  logic                rd_en;
  logic                stall;
  logic                overrun;
  logic [DATA_W-1:0]   out_data;
  logic                out_last;
  logic                out_empty;
  logic                out_full;

  // Model of packer and FIFO
  logic [ENTRY_W-1:0]  exp_q [$];
  logic [SAMPLE_W-1:0] lane_buf [LANES];
  logic [LANE_W-1:0]   lane_cnt;
  bit                  discard;
  bit                  exp_overrun;

  logic [31:0] lfsr_state;
  int          errors;
  int          checks;
  int          cycles = 0;

  sample_packer DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_sample (in_sample),
    .in_last   (in_last),
    .stall     (stall),
    .overrun   (overrun),
    .rd_en     (rd_en),
    .out_data  (out_data),
    .out_last  (out_last),
    .out_empty (out_empty),
    .out_full  (out_full)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [15:0] v);
    v = '0;
    repeat (n) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[14:0], lfsr_state[31]};
    end
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_outputs();
    logic [ENTRY_W-1:0] head;
    int                 free;
    free = FIFO_DEPTH - exp_q.size();
    check_value("out_empty", 64'(out_empty), 64'(exp_q.size() == 0));
    check_value("out_full", 64'(out_full), 64'(exp_q.size() == FIFO_DEPTH));
    check_value("stall", 64'(stall), 64'(free <= AF_FREE));
    check_value("overrun", 64'(overrun), 64'(exp_overrun));
    if (exp_q.size() > 0) begin
      head = exp_q[0];
      check_value("out_data", out_data, head[DATA_W-1:0]);
      check_value("out_last", 64'(out_last), 64'(head[DATA_W]));
    end
  endtask

  // What the coming rising edge does to FIFO and lanes
  task automatic model_edge(input logic v, input logic [15:0] s, input logic l,
                            input logic r);
    logic [ENTRY_W-1:0] entry;
    bit                 was_full;
    bit                 do_rd;
    was_full = (exp_q.size() == FIFO_DEPTH);
    do_rd    = r && (exp_q.size() > 0);
    if (do_rd)
      void'(exp_q.pop_front());
    if (discard) begin
      if (v && l)
        discard = 1'b0;
    end else if (v) begin
      lane_buf[lane_cnt] = s;
      if (lane_cnt == LANE_W'(LANES - 1) || l) begin
        if (was_full) begin
          exp_overrun = 1'b1;   // Word lost
          if (!l)
            discard = 1'b1;
        end else begin
          entry = '0;
          for (int i = 0; i < LANES; i++) begin
            if (i <= int'(lane_cnt))
              entry[i*SAMPLE_W +: SAMPLE_W] = lane_buf[i];
          end
          entry[DATA_W] = l;
          exp_q.push_back(entry);
        end
        lane_cnt = '0;
      end else begin
        lane_cnt = lane_cnt + 1'b1;
      end
    end
  endtask

  task automatic step_cycle(input logic v, input logic [15:0] s, input logic l,
                            input logic r);
    check_outputs();
    in_valid  = v;
    in_sample = s;
    in_last   = l;
    rd_en     = r;
    model_edge(v, s, l, r);
    @(negedge clk);
  endtask

  // Producer honours stall and reads are random
  task automatic normal_cycle();
    logic [15:0] vbit;
    logic [15:0] smp;
    logic [15:0] lbits;
    logic [15:0] rbit;
    take_bits(1, vbit);
    take_bits(SAMPLE_W, smp);
    take_bits(2, lbits);
    take_bits(1, rbit);
    step_cycle(vbit[0] && !stall, smp, lbits[1:0] == 2'b00, rbit[0]);
  endtask

  // Producer ignores stall and nothing is read
  task automatic overrun_cycle();
    logic [15:0] smp;
    logic [15:0] lbits;
    take_bits(SAMPLE_W, smp);
    take_bits(3, lbits);
    step_cycle(1'b1, smp, lbits[2:0] == 3'b000, 1'b0);
  endtask

  initial begin
    lfsr_state  = 32'h1b39;
    errors      = 0;
    checks      = 0;
    lane_cnt    = '0;
    discard     = 1'b0;
    exp_overrun = 1'b0;
    rst_n       = 1'b0;
    in_valid    = 1'b0;
    in_sample   = '0;
    in_last     = 1'b0;
    rd_en       = 1'b0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;

    repeat (N_NORMAL) normal_cycle();
    repeat (N_OVERRUN) overrun_cycle();
    check_value("overrun", 64'(overrun), 64'(1));
    repeat (N_RECOVER) normal_cycle();

    while (!out_empty)
      step_cycle(1'b0, '0, 1'b0, 1'b1);
    check_outputs();
    check_value("model depth", 64'(exp_q.size()), 64'(0));

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

/* vlog.f */
rtl/pack_pkg.sv
rtl/pack_ctrl_if.sv
rtl/fifo_wr_if.sv
rtl/pack_fsm.sv
rtl/lane_counter.sv
rtl/word_assembler.sv
rtl/out_fifo.sv
rtl/sample_packer.sv
testbench/tb_sample_packer.sv
